/* hdl/decoder_cfg.svh */
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// data path and instruction address width
`define DEC_XLEN 32

// architectural register index, x0..x31
`define DEC_REG_BITS 5

// reorder buffer entry index, 8 entries
`define DEC_ROB_BITS 3

// RS opcode: branch flag, func3, func7 bit 5
`define DEC_RS_TYPE_BITS 5

// LSB opcode: store flag, func3
`define DEC_LSB_TYPE_BITS 4

`endif

/* hdl/decoder_pkg.sv */
`include "decoder_cfg.svh"

package decoder_pkg;

    // RV32I major opcodes handled by the stage
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_ALUI   = 7'b0010011,
        OP_ALU    = 7'b0110011
    } opcode_e;

    // how the ROB commits the entry
    typedef enum logic [1:0] {
        ROB_REG  = 2'd0,
        ROB_REGI = 2'd1,
        ROB_BR   = 2'd2,
        ROB_ST   = 2'd3
    } rob_type_e;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]     value;
        logic                     has_dep;
        logic [`DEC_ROB_BITS-1:0] dep;      // producing ROB entry
    } reg_read_t;

    typedef struct packed {
        logic                 fi;           // entry already has its result
        logic [`DEC_XLEN-1:0] value;
    } rob_qry_t;

    typedef struct packed {
        logic [`DEC_XLEN-1:0]     value;
        logic                     has_dep;
        logic [`DEC_ROB_BITS-1:0] dep;
    } operand_t;

    typedef struct packed {
        logic                     is_lui;
        logic                     is_auipc;
        logic                     is_jal;
        logic                     is_jalr;
        logic                     is_br;
        logic                     is_ld;
        logic                     is_st;
        logic                     is_alui;
        logic                     is_alu;
        logic [`DEC_REG_BITS-1:0] rd;       // prediction bit on branches
        logic [`DEC_REG_BITS-1:0] rs1;
        logic [`DEC_REG_BITS-1:0] rs2;
        logic [2:0]               func3;
        logic                     func7_5;
        logic [`DEC_XLEN-1:0]     imm;      // already extended
        logic                     need_r2;
    } decoded_t;

    typedef struct packed {
        logic                     fi;
        logic [`DEC_XLEN-1:0]     value;
        logic [`DEC_XLEN-1:0]     addr;     // fall-through for branches
        rob_type_e                op_type;
        logic [`DEC_REG_BITS-1:0] reg_id;
    } rob_issue_t;

    typedef struct packed {
        logic [`DEC_RS_TYPE_BITS-1:0] op_type;
        operand_t                     r1;
        operand_t                     r2;
        logic [`DEC_ROB_BITS-1:0]     rob_id;
    } rs_issue_t;

    typedef struct packed {
        logic [`DEC_LSB_TYPE_BITS-1:0] op_type;
        operand_t                      r1;
        operand_t                      r2;
        logic [`DEC_XLEN-1:0]          imm;
        logic [`DEC_ROB_BITS-1:0]      rob_id;
    } lsb_issue_t;

    typedef struct packed {
        logic rob_full;
        logic rs_full;
        logic lsb_full;
    } full_t;

endpackage

/* hdl/inst_decode.sv */
`include "decoder_cfg.svh"

module inst_decode (
    input  logic [`DEC_XLEN-1:0] inst,
    output decoder_pkg::decoded_t dec
);

    // static predictor, every branch is taken
    localparam logic BR_PRED = 1'b1;

    decoder_pkg::opcode_e opcode;
    logic [2:0]           func3;
    logic                 is_shift;     // slli / srli / srai

    logic [`DEC_XLEN-1:0] imm_i;
    logic [`DEC_XLEN-1:0] imm_sh;
    logic [`DEC_XLEN-1:0] imm_s;
    logic [`DEC_XLEN-1:0] imm_b;
    logic [`DEC_XLEN-1:0] imm_u;
    logic [`DEC_XLEN-1:0] imm_j;

    assign opcode = decoder_pkg::opcode_e'(inst[6:0]);
    assign func3  = inst[14:12];

    // immediate layouts of the base ISA
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_sh = {27'b0, inst[24:20]};
    assign imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u  = {inst[31:12], 12'b0};
    assign imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    assign is_shift = (opcode == decoder_pkg::OP_ALUI) && (func3[1:0] == 2'b01);

    always_comb begin
        dec = '0;

        dec.is_lui   = (opcode == decoder_pkg::OP_LUI);
        dec.is_auipc = (opcode == decoder_pkg::OP_AUIPC);
        dec.is_jal   = (opcode == decoder_pkg::OP_JAL);
        dec.is_jalr  = (opcode == decoder_pkg::OP_JALR);
        dec.is_br    = (opcode == decoder_pkg::OP_BRANCH);
        dec.is_ld    = (opcode == decoder_pkg::OP_LOAD);
        dec.is_st    = (opcode == decoder_pkg::OP_STORE);
        dec.is_alui  = (opcode == decoder_pkg::OP_ALUI);
        dec.is_alu   = (opcode == decoder_pkg::OP_ALU);

        dec.rs1     = inst[19:15];
        dec.rs2     = inst[24:20];
        dec.func3   = func3;
        dec.func7_5 = inst[30];

        // branches write no register, rd slot carries the prediction
        if (dec.is_br) begin
            dec.rd = {{(`DEC_REG_BITS-1){1'b0}}, BR_PRED};
        end else begin
            dec.rd = inst[11:7];
        end

        if (is_shift) begin
            dec.imm = imm_sh;           // shamt only
        end else if (dec.is_ld || dec.is_jalr || dec.is_alui) begin
            dec.imm = imm_i;
        end else if (dec.is_st) begin
            dec.imm = imm_s;
        end else if (dec.is_br) begin
            dec.imm = imm_b;
        end else if (dec.is_lui || dec.is_auipc) begin
            dec.imm = imm_u;
        end else if (dec.is_jal) begin
            dec.imm = imm_j;
        end else begin
            dec.imm = '0;
        end

        // immediate takes the place of rs2
        dec.need_r2 = !dec.is_alui;
    end

endmodule

/* hdl/operand_resolve.sv */
`include "decoder_cfg.svh"

module operand_resolve (
    input  decoder_pkg::reg_read_t rf,
    input  decoder_pkg::rob_qry_t  qry,
    input  logic                   need,
    output decoder_pkg::operand_t  opnd
);

    // RF answer is already up to date with this cycle's commits,
    // the ROB answer covers results broadcast but not yet committed
    always_comb begin
        opnd = '0;
        if (!need) begin
            opnd = '0;                  // operand unused
        end else if (!rf.has_dep) begin
            opnd.value   = rf.value;
            opnd.has_dep = 1'b0;
            opnd.dep     = '0;
        end else if (qry.fi) begin
            opnd.value   = qry.value;   // forwarded from ROB
            opnd.has_dep = 1'b0;
            opnd.dep     = '0;
        end else begin
            // still in flight, RS/LSB will snoop for it
            opnd.value   = '0;
            opnd.has_dep = 1'b1;
            opnd.dep     = rf.dep;
        end
    end

endmodule

/* hdl/next_pc_calc.sv */
`include "decoder_cfg.svh"

module next_pc_calc (
    input  decoder_pkg::decoded_t dec,
    input  logic [`DEC_XLEN-1:0]  inst_addr,
    input  decoder_pkg::operand_t r1,
    input  logic                  inst_input,
    input  logic                  rob_clear,
    input  decoder_pkg::full_t    full,
    output logic [`DEC_XLEN-1:0]  next_pc,
    output logic                  is_stall
);

    logic any_full;
    logic jalr_wait;

    assign any_full = full.rob_full || full.rs_full || full.lsb_full;

    // target of jalr unknown until rs1 resolves
    assign jalr_wait = dec.is_jalr && r1.has_dep;

    assign is_stall = !inst_input || rob_clear || any_full || jalr_wait;

    // dec.imm already holds immJ / immB / immI for these classes
    always_comb begin
        if (dec.is_jal || dec.is_br) begin
            next_pc = inst_addr + dec.imm;   // branches predicted taken
        end else if (dec.is_jalr) begin
            next_pc = r1.value + dec.imm;    // bit 0 kept as is
        end else begin
            next_pc = inst_addr + `DEC_XLEN'(4);
        end
    end

endmodule

/* hdl/issue_reg.sv */
`include "decoder_cfg.svh"

module issue_reg (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     rdy_in,
    input  logic                     is_stall,
    input  decoder_pkg::decoded_t    dec,
    input  logic [`DEC_XLEN-1:0]     inst_addr,
    input  decoder_pkg::operand_t    r1,
    input  decoder_pkg::operand_t    r2,
    input  logic [`DEC_ROB_BITS-1:0] rob_vacant_id,
    output logic                     rob_input,
    output logic                     rs_input,
    output logic                     lsb_input,
    output decoder_pkg::rob_issue_t  rob_rec,
    output decoder_pkg::rs_issue_t   rs_rec,
    output decoder_pkg::lsb_issue_t  lsb_rec
);

    decoder_pkg::rob_issue_t rob_nxt;
    decoder_pkg::rs_issue_t  rs_nxt;
    decoder_pkg::lsb_issue_t lsb_nxt;

    logic [`DEC_XLEN-1:0] pc_plus4;
    logic                 need_rs;
    logic                 need_lsb;
    logic                 rs_low;       // func7[5] slot of the RS opcode

    assign pc_plus4 = inst_addr + `DEC_XLEN'(4);
    assign need_rs  = dec.is_alu || dec.is_alui || dec.is_br;
    assign need_lsb = dec.is_ld || dec.is_st;

    // sub / sra / srai need bit 30, addi etc. must ignore it
    assign rs_low = dec.is_alu || (dec.is_alui && dec.func3 == 3'b101) ? dec.func7_5 : 1'b0;

    always_comb begin
        rob_nxt = '0;
        rob_nxt.fi     = dec.is_lui || dec.is_auipc || dec.is_jal || dec.is_jalr;
        rob_nxt.reg_id = dec.rd;

        if (dec.is_lui) begin
            rob_nxt.value = dec.imm;
        end else if (dec.is_auipc) begin
            rob_nxt.value = inst_addr + dec.imm;
        end else if (dec.is_jal || dec.is_jalr) begin
            rob_nxt.value = pc_plus4;   // link address
        end

        // ROB restarts from here on a mispredict
        if (dec.is_br) begin
            rob_nxt.addr = pc_plus4;
        end

        if (dec.is_alui) begin
            rob_nxt.op_type = decoder_pkg::ROB_REGI;
        end else if (dec.is_br) begin
            rob_nxt.op_type = decoder_pkg::ROB_BR;
        end else if (dec.is_st) begin
            rob_nxt.op_type = decoder_pkg::ROB_ST;
        end else begin
            rob_nxt.op_type = decoder_pkg::ROB_REG;
        end
    end

    always_comb begin
        rs_nxt = '0;
        rs_nxt.op_type = {dec.is_br, dec.func3, rs_low};
        rs_nxt.r1      = r1;
        rs_nxt.rob_id  = rob_vacant_id;
        if (dec.is_alui) begin
            rs_nxt.r2.value = dec.imm;  // immediate rides in r2
        end else begin
            rs_nxt.r2 = r2;
        end

        lsb_nxt = '0;
        lsb_nxt.op_type = {dec.is_st, dec.func3};
        lsb_nxt.r1      = r1;
        lsb_nxt.r2      = r2;           // store data
        lsb_nxt.imm     = dec.imm;
        lsb_nxt.rob_id  = rob_vacant_id;
    end

    always_ff @(posedge clk_in or posedge rst_in) begin
        if (rst_in) begin
            rob_input <= 1'b0;
            rs_input  <= 1'b0;
            lsb_input <= 1'b0;
            rob_rec   <= '0;
            rs_rec    <= '0;
            lsb_rec   <= '0;
        end else if (rdy_in) begin
            if (is_stall) begin
                // records keep old contents, strobes say they are stale
                rob_input <= 1'b0;
                rs_input  <= 1'b0;
                lsb_input <= 1'b0;
            end else begin
                rob_input <= 1'b1;
                rs_input  <= need_rs;
                lsb_input <= need_lsb;
                rob_rec   <= rob_nxt;
                rs_rec    <= rs_nxt;
                lsb_rec   <= lsb_nxt;
            end
        end
    end

endmodule

/* hdl/decoder_top.sv */
`include "decoder_cfg.svh"

module decoder_top (
    input  logic                     clk_in,
    input  logic                     rst_in,
    input  logic                     rdy_in,    // low freezes the stage

    // fetch side
    input  logic                     inst_input,
    input  logic [`DEC_XLEN-1:0]     inst,
    input  logic [`DEC_XLEN-1:0]     inst_addr,
    output logic                     is_stall,
    output logic [`DEC_XLEN-1:0]     next_pc,

    // register file lookups
    output logic [`DEC_REG_BITS-1:0] rs1_id,
    output logic [`DEC_REG_BITS-1:0] rs2_id,
    input  decoder_pkg::reg_read_t   rf1,
    input  decoder_pkg::reg_read_t   rf2,

    // ROB lookups and allocation
    output logic [`DEC_ROB_BITS-1:0] rob_qry1_id,
    output logic [`DEC_ROB_BITS-1:0] rob_qry2_id,
    input  decoder_pkg::rob_qry_t    rob_qry1,
    input  decoder_pkg::rob_qry_t    rob_qry2,
    input  logic [`DEC_ROB_BITS-1:0] rob_vacant_id,
    input  logic                     rob_clear,
    input  decoder_pkg::full_t       full,

    // issue records, one cycle after acceptance
    output logic                     rob_input,
    output decoder_pkg::rob_issue_t  rob_rec,
    output logic                     rs_input,
    output decoder_pkg::rs_issue_t   rs_rec,
    output logic                     lsb_input,
    output decoder_pkg::lsb_issue_t  lsb_rec
);

    decoder_pkg::decoded_t dec;
    decoder_pkg::operand_t opnd1;
    decoder_pkg::operand_t opnd2;

    assign rs1_id      = dec.rs1;
    assign rs2_id      = dec.rs2;
    assign rob_qry1_id = rf1.dep;   // ask ROB for whatever the RF waits on
    assign rob_qry2_id = rf2.dep;

    inst_decode u_decode (
        .inst (inst),
        .dec  (dec)
    );

    operand_resolve u_opnd1 (
        .rf   (rf1),
        .qry  (rob_qry1),
        .need (1'b1),
        .opnd (opnd1)
    );

    operand_resolve u_opnd2 (
        .rf   (rf2),
        .qry  (rob_qry2),
        .need (dec.need_r2),
        .opnd (opnd2)
    );

    next_pc_calc u_next_pc (
        .dec        (dec),
        .inst_addr  (inst_addr),
        .r1         (opnd1),
        .inst_input (inst_input),
        .rob_clear  (rob_clear),
        .full       (full),
        .next_pc    (next_pc),
        .is_stall   (is_stall)
    );

    issue_reg u_issue (
        .clk_in        (clk_in),
        .rst_in        (rst_in),
        .rdy_in        (rdy_in),
        .is_stall      (is_stall),
        .dec           (dec),
        .inst_addr     (inst_addr),
        .r1            (opnd1),
        .r2            (opnd2),
        .rob_vacant_id (rob_vacant_id),
        .rob_input     (rob_input),
        .rs_input      (rs_input),
        .lsb_input     (lsb_input),
        .rob_rec       (rob_rec),
        .rs_rec        (rs_rec),
        .lsb_rec       (lsb_rec)
    );

endmodule

/* verification/decoder_ref.svh */
`ifndef DECODER_REF_SVH
`define DECODER_REF_SVH

`include "decoder_cfg.svh"

// everything the stage should show for one instruction
typedef struct packed {
    logic                    is_stall;
    logic [`DEC_XLEN-1:0]    next_pc;
    logic                    rob_input;
    logic                    rs_input;
    logic                    lsb_input;
    decoder_pkg::rob_issue_t rob_rec;
    decoder_pkg::rs_issue_t  rs_rec;
    decoder_pkg::lsb_issue_t lsb_rec;
} expect_t;

function automatic decoder_pkg::operand_t expect_operand(
    input decoder_pkg::reg_read_t rf_ans,
    input decoder_pkg::rob_qry_t  rob_ans
);
    decoder_pkg::operand_t o;
    o = '0;
    if (!rf_ans.has_dep) begin
        o.value = rf_ans.value;
    end else if (rob_ans.fi) begin
        o.value = rob_ans.value;      // finished in ROB
    end else begin
        o.has_dep = 1'b1;
        o.dep     = rf_ans.dep;
    end
    return o;
endfunction

function automatic expect_t predict_issue(
    input logic [`DEC_XLEN-1:0]     w,
    input logic [`DEC_XLEN-1:0]     pc,
    input logic                     valid,
    input logic                     clear,
    input decoder_pkg::full_t       fl,
    input decoder_pkg::reg_read_t   rf_tbl [1 << `DEC_REG_BITS],
    input decoder_pkg::rob_qry_t    rob_tbl [1 << `DEC_ROB_BITS],
    input logic [`DEC_ROB_BITS-1:0] vacant
);
    expect_t               e;
    decoder_pkg::operand_t a;
    decoder_pkg::operand_t b;
    logic [6:0]            opc;
    logic [`DEC_XLEN-1:0]  imm;
    logic [`DEC_XLEN-1:0]  pc4;
    logic                  shift_i;
    e       = '0;
    opc     = w[6:0];
    pc4     = pc + 32'd4;
    shift_i = (opc == decoder_pkg::OP_ALUI) && (w[13:12] == 2'b01);
    a = expect_operand(rf_tbl[w[19:15]], rob_tbl[rf_tbl[w[19:15]].dep]);
    b = '0;
    if (opc != decoder_pkg::OP_ALUI) begin
        b = expect_operand(rf_tbl[w[24:20]], rob_tbl[rf_tbl[w[24:20]].dep]);
    end

    case (opc)
        decoder_pkg::OP_LUI,
        decoder_pkg::OP_AUIPC:  imm = {w[31:12], 12'b0};
        decoder_pkg::OP_JAL:    imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        decoder_pkg::OP_BRANCH: imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        decoder_pkg::OP_STORE:  imm = {{21{w[31]}}, w[30:25], w[11:7]};
        decoder_pkg::OP_ALU:    imm = '0;
        default:                imm = shift_i ? {27'b0, w[24:20]} : {{21{w[31]}}, w[30:20]};
    endcase

    e.is_stall = !valid || clear || fl.rob_full || fl.rs_full || fl.lsb_full
                 || (opc == decoder_pkg::OP_JALR && a.has_dep);
    case (opc)
        decoder_pkg::OP_JAL,
        decoder_pkg::OP_BRANCH: e.next_pc = pc + imm;     // always taken
        decoder_pkg::OP_JALR:   e.next_pc = a.value + imm;
        default:                e.next_pc = pc4;
    endcase

    e.rob_rec.fi = (opc == decoder_pkg::OP_LUI) || (opc == decoder_pkg::OP_AUIPC)
                   || (opc == decoder_pkg::OP_JAL) || (opc == decoder_pkg::OP_JALR);
    e.rob_rec.reg_id = (opc == decoder_pkg::OP_BRANCH) ? 5'd1 : w[11:7];
    case (opc)
        decoder_pkg::OP_LUI:   e.rob_rec.value = imm;
        decoder_pkg::OP_AUIPC: e.rob_rec.value = pc + imm;
        decoder_pkg::OP_JAL,
        decoder_pkg::OP_JALR:  e.rob_rec.value = pc4;
        default:               e.rob_rec.value = '0;
    endcase
    case (opc)
        decoder_pkg::OP_ALUI:  e.rob_rec.op_type = decoder_pkg::ROB_REGI;
        decoder_pkg::OP_STORE: e.rob_rec.op_type = decoder_pkg::ROB_ST;
        decoder_pkg::OP_BRANCH: begin
            e.rob_rec.op_type = decoder_pkg::ROB_BR;
            e.rob_rec.addr    = pc4;   // fall-through
        end
        default:               e.rob_rec.op_type = decoder_pkg::ROB_REG;
    endcase

    e.rs_rec.op_type = {opc == decoder_pkg::OP_BRANCH, w[14:12],
                        ((opc == decoder_pkg::OP_ALU)
                         || (opc == decoder_pkg::OP_ALUI && w[14:12] == 3'b101)) & w[30]};
    e.rs_rec.r1     = a;
    e.rs_rec.r2     = b;
    e.rs_rec.rob_id = vacant;
    if (opc == decoder_pkg::OP_ALUI) begin
        e.rs_rec.r2.value = imm;
    end

    e.lsb_rec.op_type = {opc == decoder_pkg::OP_STORE, w[14:12]};
    e.lsb_rec.r1      = a;
    e.lsb_rec.r2      = b;
    e.lsb_rec.imm     = imm;
    e.lsb_rec.rob_id  = vacant;

    e.rob_input = !e.is_stall;
    e.rs_input  = !e.is_stall && ((opc == decoder_pkg::OP_ALU)
                  || (opc == decoder_pkg::OP_ALUI) || (opc == decoder_pkg::OP_BRANCH));
    e.lsb_input = !e.is_stall
                  && ((opc == decoder_pkg::OP_LOAD) || (opc == decoder_pkg::OP_STORE));
    return e;
endfunction

`endif

/* verification/decoder_tb.sv */
`include "decoder_cfg.svh"

module decoder_tb;

    localparam int N_RAND      = 300;
    localparam int N_STALL     = 6;
    localparam int N_HOLD      = 6;
    localparam int STIM_CYCLES = 5 + N_RAND + 2 * N_STALL + N_HOLD + 5;
    localparam int MAX_CYCLES  = 2 * STIM_CYCLES + 50;

    logic                     clk_in;
    logic                     rst_in;
    logic                     rdy_in;
    logic                     inst_input;
    logic [`DEC_XLEN-1:0]     inst;
    logic [`DEC_XLEN-1:0]     inst_addr;
    logic                     is_stall;
    logic [`DEC_XLEN-1:0]     next_pc;
    logic [`DEC_REG_BITS-1:0] rs1_id;
    logic [`DEC_REG_BITS-1:0] rs2_id;
    decoder_pkg::reg_read_t   rf1;
    decoder_pkg::reg_read_t   rf2;
    logic [`DEC_ROB_BITS-1:0] rob_qry1_id;
    logic [`DEC_ROB_BITS-1:0] rob_qry2_id;
    decoder_pkg::rob_qry_t    rob_qry1;
    decoder_pkg::rob_qry_t    rob_qry2;
    logic [`DEC_ROB_BITS-1:0] rob_vacant_id;
    logic                     rob_clear;
    decoder_pkg::full_t       full;
    logic                     rob_input;
    decoder_pkg::rob_issue_t  rob_rec;
    logic                     rs_input;
    decoder_pkg::rs_issue_t   rs_rec;
    logic                     lsb_input;
    decoder_pkg::lsb_issue_t  lsb_rec;

    decoder_pkg::reg_read_t rf_mem [1 << `DEC_REG_BITS];
    decoder_pkg::rob_qry_t  rob_mem [1 << `DEC_ROB_BITS];

    int cycle_cnt = 0;
    int n_checks  = 0;
    int err_pc    = 0;    // lookup ids, is_stall and next_pc
    int err_rec   = 0;    // strobes and records

    `include "decoder_ref.svh"

    expect_t held = '0;   // what the issue registers should hold now

    decoder_top i_dut (.*);

    // RF and ROB answer straight from the lookup ids
    assign rf1      = rf_mem[rs1_id];
    assign rf2      = rf_mem[rs2_id];
    assign rob_qry1 = rob_mem[rob_qry1_id];
    assign rob_qry2 = rob_mem[rob_qry2_id];

    initial begin
        clk_in = 1'b0;
        forever #50 clk_in = ~clk_in;
    end

    always @(posedge clk_in) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [`DEC_XLEN-1:0] make_inst(input int cls);
        logic [`DEC_XLEN-1:0] w;
        logic [2:0]           f3;
        w  = $urandom;
        f3 = w[14:12];
        case (cls)
            0: w[6:0] = decoder_pkg::OP_LUI;
            1: w[6:0] = decoder_pkg::OP_AUIPC;
            2: w[6:0] = decoder_pkg::OP_JAL;
            3: begin
                w[6:0] = decoder_pkg::OP_JALR;
                f3     = 3'b000;
            end
            4: begin
                w[6:0] = decoder_pkg::OP_BRANCH;
                f3[2]  = f3[2] | f3[1];     // no 010 / 011
            end
            5: begin
                w[6:0] = decoder_pkg::OP_LOAD;
                f3[1]  = f3[1] & ~f3[2];
                f3[0]  = f3[0] & ~f3[1];
            end
            6: begin
                w[6:0] = decoder_pkg::OP_STORE;
                f3[2]  = 1'b0;
                f3[0]  = f3[0] & ~f3[1];
            end
            7: begin
                w[6:0] = decoder_pkg::OP_ALUI;
                if (f3[1:0] == 2'b01) begin
                    w[31:25] = {1'b0, w[30] & f3[2], 5'b0};  // slli / srli / srai
                end
            end
            default: begin
                w[6:0]   = decoder_pkg::OP_ALU;
                w[31:25] = {1'b0, w[30], 5'b0};
            end
        endcase
        w[14:12] = f3;
        return w;
    endfunction

    // about half the registers wait on the ROB and half of those finished
    task automatic randomize_models();
        logic [31:0] r;
        for (int i = 0; i < (1 << `DEC_REG_BITS); i++) begin
            r = $urandom;
            rf_mem[i].value   = $urandom;
            rf_mem[i].has_dep = r[0];
            rf_mem[i].dep     = r[3:1];
        end
        for (int i = 0; i < (1 << `DEC_ROB_BITS); i++) begin
            r = $urandom;
            rob_mem[i].fi    = r[0];
            rob_mem[i].value = $urandom;
        end
    endtask

    task automatic present(input logic [`DEC_XLEN-1:0] word);
        logic [31:0] r;
        @(posedge clk_in);
        #10;
        randomize_models();
        r             = $urandom;
        rob_vacant_id = r[2:0];
        r             = $urandom;
        inst_addr     = {r[31:2], 2'b00};
        inst          = word;
        inst_input    = 1'b1;
        rob_clear     = 1'b0;
        full          = '0;
        rdy_in        = 1'b1;
    endtask

    always @(negedge clk_in) begin : compare
        expect_t now;
        n_checks++;
        if ({rob_input, rs_input, lsb_input} !== {held.rob_input, held.rs_input,
                                                   held.lsb_input}) begin
            err_rec++;
            $display("CHECK FAILED at %0t: strobes rob/rs/lsb %b%b%b, expected %b%b%b",
                     $time, rob_input, rs_input, lsb_input,
                     held.rob_input, held.rs_input, held.lsb_input);
        end
        if (rob_rec !== held.rob_rec) begin
            err_rec++;
            $display("CHECK FAILED at %0t: rob_rec %h, expected %h", $time, rob_rec, held.rob_rec);
        end
        if (rs_rec !== held.rs_rec) begin
            err_rec++;
            $display("CHECK FAILED at %0t: rs_rec %h, expected %h", $time, rs_rec, held.rs_rec);
        end
        if (lsb_rec !== held.lsb_rec) begin
            err_rec++;
            $display("CHECK FAILED at %0t: lsb_rec %h, expected %h", $time, lsb_rec, held.lsb_rec);
        end

        // RF is asked for the source fields, ROB for what the RF waits on
        if ({rs1_id, rs2_id} !== {inst[19:15], inst[24:20]}
            || {rob_qry1_id, rob_qry2_id}
               !== {rf_mem[inst[19:15]].dep, rf_mem[inst[24:20]].dep}) begin
            err_pc++;
            $display("CHECK FAILED at %0t: lookup ids %h %h %h %h, inst %h",
                     $time, rs1_id, rs2_id, rob_qry1_id, rob_qry2_id, inst);
        end

        now = predict_issue(inst, inst_addr, inst_input, rob_clear, full,
                            rf_mem, rob_mem, rob_vacant_id);
        if (is_stall !== now.is_stall) begin
            err_pc++;
            $display("CHECK FAILED at %0t: is_stall %b, expected %b, inst %h",
                     $time, is_stall, now.is_stall, inst);
        end
        if (next_pc !== now.next_pc) begin
            err_pc++;
            $display("CHECK FAILED at %0t: next_pc %h, expected %h, inst %h",
                     $time, next_pc, now.next_pc, inst);
        end

        // registers after the coming edge
        if (rst_in) begin
            held = '0;
        end else if (rdy_in) begin
            held.rob_input = now.rob_input;
            held.rs_input  = now.rs_input;
            held.lsb_input = now.lsb_input;
            if (!now.is_stall) begin
                held.rob_rec = now.rob_rec;
                held.rs_rec  = now.rs_rec;
                held.lsb_rec = now.lsb_rec;
            end
        end
    end

    initial begin
        void'($urandom(32'h6ef7_efa1));
        rst_in        = 1'b1;
        rdy_in        = 1'b1;
        inst_input    = 1'b0;
        inst          = 32'h0000_0013;   // nop
        inst_addr     = '0;
        rob_vacant_id = '0;
        rob_clear     = 1'b0;
        full          = '0;
        randomize_models();
        repeat (5) @(posedge clk_in);
        #10 rst_in = 1'b0;

        for (int k = 0; k < N_RAND; k++) begin
            present(make_inst($urandom % 9));
        end

        // one stall source per round on a load that would raise lsb_input
        for (int k = 0; k < N_STALL; k++) begin
            present(make_inst(8));
            present(make_inst(k == 5 ? 3 : 5));
            case (k)
                0: inst_input = 1'b0;
                1: full.rob_full = 1'b1;
                2: full.rs_full = 1'b1;
                3: full.lsb_full = 1'b1;
                4: rob_clear = 1'b1;
                default: begin
                    rf_mem[inst[19:15]].has_dep          = 1'b1;
                    rob_mem[rf_mem[inst[19:15]].dep].fi = 1'b0;
                end
            endcase
        end

        present(make_inst(7));
        for (int k = 0; k < N_HOLD; k++) begin
            present(make_inst($urandom % 9));
            rdy_in = 1'b0;
        end
        present(make_inst(4));
        present(make_inst(6));
        repeat (2) @(posedge clk_in);

        $display("checks %0d, errors %0d (combinational %0d, issue %0d)",
                 n_checks, err_pc + err_rec, err_pc, err_rec);
        if (err_pc + err_rec == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+hdl
+incdir+verification
hdl/decoder_pkg.sv
hdl/inst_decode.sv
hdl/operand_resolve.sv
hdl/next_pc_calc.sv
hdl/issue_reg.sv
hdl/decoder_top.sv
verification/decoder_tb.sv
